/* files.f */
+incdir+rtl
rtl/mipsIsaPkg.sv
rtl/mipsCtrlPkg.sv
rtl/Controller.sv
rtl/RegisterFile.sv
rtl/Alu.sv
rtl/NextPcUnit.sv
rtl/LoadStoreUnit.sv
rtl/MipsCore.sv
verif/clockGen.sv
verif/coreTb.sv

/* rtl/Alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module Alu (
    input  mipsCtrlPkg::aluOp_t  op,
    input  logic [`DATA_W-1:0]   a,
    input  logic [`DATA_W-1:0]   b,
    output logic [`DATA_W-1:0]   result
);

    import mipsCtrlPkg::*;

    // Shift amount comes from the low bits of a
    logic [4:0] shiftAmt;

    assign shiftAmt = a[4:0];

    always_comb begin
        result = '0;
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluSlt: result[0] = ($signed(a) < $signed(b));
            aluSll: result = b << shiftAmt;
            aluSrl: result = b >> shiftAmt;
            // low word of the signed product
            aluMul: result = $signed(a) * $signed(b);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/Controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module Controller (
    input  mipsIsaPkg::opcode_t         opcode,
    input  mipsIsaPkg::funct_t          funct,
    input  logic [`REG_IDX_W-1:0]       rtField,
    output mipsCtrlPkg::branchKind_t    branchKind,
    output mipsCtrlPkg::aluOp_t         aluOp,
    output logic                        aluSrcShamt,
    output logic                        aluSrcImm,
    output logic                        signExt,
    output logic                        regDst,
    output logic                        regWrite,
    output mipsCtrlPkg::wbSel_t         wbSel,
    output logic                        readEn,
    output logic                        writeEn,
    output mipsCtrlPkg::accessWidth_t   accessWidth
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    always_comb begin
        // Inert defaults so an unknown opcode does nothing
        branchKind  = brNone;
        aluOp       = aluAdd;
        aluSrcShamt = 1'b0;
        aluSrcImm   = 1'b0;
        signExt     = 1'b0;
        regDst      = 1'b0;
        regWrite    = 1'b0;
        wbSel       = wbAlu;
        readEn      = 1'b0;
        writeEn     = 1'b0;
        accessWidth = accWord;

        case (opcode)
            ////////////////////////////////////////////////////////////////////////////
            // Register format
            opSpecial: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSll: begin
                        aluOp       = aluSll;
                        aluSrcShamt = 1'b1;
                    end
                    fnSrl: begin
                        aluOp       = aluSrl;
                        aluSrcShamt = 1'b1;
                    end
                    fnJr: begin
                        regWrite   = 1'b0;
                        branchKind = brJumpReg;
                    end
                    default: regWrite = 1'b0;
                endcase
            end

            opSpecial2: begin
                // Only mul is decoded here
                if (funct == fnMul) begin
                    aluOp    = aluMul;
                    regDst   = 1'b1;
                    regWrite = 1'b1;
                end
            end

            ////////////////////////////////////////////////////////////////////////////
            // Branches and jumps
            opRegimm: begin
                signExt = 1'b1;
                case (rtField)
                    rtBltz:  branchKind = brBltz;
                    rtBgez:  branchKind = brBgez;
                    default: branchKind = brNone;
                endcase
            end
            opBeq: begin
                signExt    = 1'b1;
                branchKind = brBeq;
            end
            opBne: begin
                signExt    = 1'b1;
                branchKind = brBne;
            end
            opBgtz: begin
                signExt    = 1'b1;
                branchKind = brBgtz;
            end
            opBlez: begin
                signExt    = 1'b1;
                branchKind = brBlez;
            end
            opJ: branchKind = brJump;
            opJal: begin
                branchKind = brJumpLink;
                regWrite   = 1'b1;
                wbSel      = wbLink;
            end

            ////////////////////////////////////////////////////////////////////////////
            // Immediate arithmetic
            opAddi, opSlti: begin
                aluOp     = (opcode == opSlti) ? aluSlt : aluAdd;
                aluSrcImm = 1'b1;
                signExt   = 1'b1;
                regWrite  = 1'b1;
            end
            // Logical immediates are zero-extended
            opOri, opXori: begin
                aluOp     = (opcode == opOri) ? aluOr : aluXor;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end

            ////////////////////////////////////////////////////////////////////////////
            // Memory access, address is rs plus offset
            opLw, opLh, opLb: begin
                aluSrcImm = 1'b1;
                signExt   = 1'b1;
                readEn    = 1'b1;
                regWrite  = 1'b1;
                wbSel     = wbLoad;
                case (opcode)
                    opLh:    accessWidth = accHalf;
                    opLb:    accessWidth = accByte;
                    default: accessWidth = accWord;
                endcase
            end
            opSw, opSh, opSb: begin
                aluSrcImm = 1'b1;
                signExt   = 1'b1;
                writeEn   = 1'b1;
                case (opcode)
                    opSh:    accessWidth = accHalf;
                    opSb:    accessWidth = accByte;
                    default: accessWidth = accWord;
                endcase
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/LoadStoreUnit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module LoadStoreUnit (
    input  logic [`DATA_W-1:0]        addr,
    input  logic [`DATA_W-1:0]        storeData,
    input  logic                      readEn,
    input  logic                      writeEn,
    input  mipsCtrlPkg::accessWidth_t width,
    input  logic [`DATA_W-1:0]        dmemRData,
    output logic [`DATA_W-1:0]        dmemAddr,
    output logic [`DATA_W-1:0]        dmemWData,
    output logic [3:0]                dmemByteEn,
    output logic                      dmemWe,
    output logic                      dmemRe,
    output logic [`DATA_W-1:0]        loadData
);

    import mipsCtrlPkg::*;

    logic [3:0]  laneMask;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    assign dmemAddr = {addr[`DATA_W-1:2], 2'b00};
    assign dmemWe   = writeEn;
    assign dmemRe   = readEn;

    ////////////////////////////////////////////////////////////////////////////
    // Store side, big-endian so offset 0 is the top byte lane
    always_comb begin
        case (width)
            accByte: begin
                laneMask  = 4'b1000 >> addr[1:0];
                dmemWData = {4{storeData[7:0]}};
            end
            accHalf: begin
                laneMask  = addr[1] ? 4'b0011 : 4'b1100;
                dmemWData = {2{storeData[15:0]}};
            end
            default: begin
                laneMask  = 4'b1111;
                dmemWData = storeData;
            end
        endcase
    end

    assign dmemByteEn = (readEn || writeEn) ? laneMask : 4'b0000;

    ////////////////////////////////////////////////////////////////////////////
    // Load side
    assign loadByte = dmemRData[(3 - addr[1:0]) * 8 +: 8];
    assign loadHalf = addr[1] ? dmemRData[15:0] : dmemRData[31:16];

    always_comb begin
        case (width)
            accByte: loadData = {{(`DATA_W-8){loadByte[7]}}, loadByte};
            accHalf: loadData = {{(`DATA_W-16){loadHalf[15]}}, loadHalf};
            default: loadData = dmemRData;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/MipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module MipsCore (
    input  logic               clk,
    input  logic               arstN,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] dmemRData,
    output logic [`DATA_W-1:0] pc,
    output logic [`DATA_W-1:0] dmemAddr,
    output logic [`DATA_W-1:0] dmemWData,
    output logic [3:0]         dmemByteEn,
    output logic               dmemWe,
    output logic               dmemRe
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    instrWord_t instrWord;

    branchKind_t  branchKind;
    aluOp_t       aluOp;
    wbSel_t       wbSel;
    accessWidth_t accessWidth;
    logic         aluSrcShamt;
    logic         aluSrcImm;
    logic         signExt;
    logic         regDst;
    logic         regWrite;
    logic         readEn;
    logic         writeEn;

    logic [`REG_IDX_W-1:0] writeAddr;
    logic [`DATA_W-1:0]    writeData;
    logic [`DATA_W-1:0]    rsData;
    logic [`DATA_W-1:0]    rtData;
    logic [`DATA_W-1:0]    immExt;
    logic [`DATA_W-1:0]    aluA;
    logic [`DATA_W-1:0]    aluB;
    logic [`DATA_W-1:0]    aluResult;
    logic [`DATA_W-1:0]    loadData;
    logic [`DATA_W-1:0]    nextPc;
    logic [`DATA_W-1:0]    linkAddr;

    assign instrWord = instr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    Controller uController (
        .opcode      (instrWord.rFormat.opcode),
        .funct       (instrWord.rFormat.funct),
        .rtField     (instrWord.rFormat.rt),
        .branchKind  (branchKind),
        .aluOp       (aluOp),
        .aluSrcShamt (aluSrcShamt),
        .aluSrcImm   (aluSrcImm),
        .signExt     (signExt),
        .regDst      (regDst),
        .regWrite    (regWrite),
        .wbSel       (wbSel),
        .readEn      (readEn),
        .writeEn     (writeEn),
        .accessWidth (accessWidth)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection
    assign immExt = signExt
        ? {{(`DATA_W-16){instrWord.iFormat.imm[15]}}, instrWord.iFormat.imm}
        : {{(`DATA_W-16){1'b0}}, instrWord.iFormat.imm};
    assign aluA = aluSrcShamt ? {{(`DATA_W-5){1'b0}}, instrWord.rFormat.shamt} : rsData;
    assign aluB = aluSrcImm ? immExt : rtData;

    Alu uAlu (
        .op     (aluOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult)
    );

    NextPcUnit uNextPc (
        .pc       (pc),
        .rsData   (rsData),
        .rtData   (rtData),
        .offset   (immExt),
        .target   (instrWord.jFormat.target),
        .kind     (branchKind),
        .nextPc   (nextPc),
        .linkAddr (linkAddr)
    );

    // No memory traffic while held in reset
    LoadStoreUnit uLsu (
        .addr       (aluResult),
        .storeData  (rtData),
        .readEn     (readEn && arstN),
        .writeEn    (writeEn && arstN),
        .width      (accessWidth),
        .dmemRData  (dmemRData),
        .dmemAddr   (dmemAddr),
        .dmemWData  (dmemWData),
        .dmemByteEn (dmemByteEn),
        .dmemWe     (dmemWe),
        .dmemRe     (dmemRe),
        .loadData   (loadData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Write-back, link always goes to r31
    always_comb begin
        if (wbSel == wbLink) begin
            writeAddr = {`REG_IDX_W{1'b1}};
        end else begin
            writeAddr = regDst ? instrWord.rFormat.rd : instrWord.rFormat.rt;
        end
        case (wbSel)
            wbLoad:  writeData = loadData;
            wbLink:  writeData = linkAddr;
            default: writeData = aluResult;
        endcase
    end

    RegisterFile uRegFile (
        .clk       (clk),
        .arstN     (arstN),
        .rsAddr    (instrWord.rFormat.rs),
        .rtAddr    (instrWord.rFormat.rt),
        .writeAddr (writeAddr),
        .writeEn   (regWrite),
        .writeData (writeData),
        .rsData    (rsData),
        .rtData    (rtData)
    );

endmodule

`default_nettype wire

/* rtl/NextPcUnit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module NextPcUnit (
    input  logic [`DATA_W-1:0]       pc,
    input  logic [`DATA_W-1:0]       rsData,
    input  logic [`DATA_W-1:0]       rtData,
    input  logic [`DATA_W-1:0]       offset,
    input  logic [25:0]              target,
    input  mipsCtrlPkg::branchKind_t kind,
    output logic [`DATA_W-1:0]       nextPc,
    output logic [`DATA_W-1:0]       linkAddr
);

    import mipsCtrlPkg::*;

    logic [`DATA_W-1:0] pcPlus4;
    logic [`DATA_W-1:0] branchTarget;
    logic [`DATA_W-1:0] jumpTarget;
    logic               taken;

    assign pcPlus4      = pc + `DATA_W'(4);
    assign branchTarget = pcPlus4 + {offset[`DATA_W-3:0], 2'b00};
    // Region bits from the delay-slot address
    assign jumpTarget   = {pcPlus4[`DATA_W-1 -: 4], target, 2'b00};
    assign linkAddr     = pcPlus4;

    ////////////////////////////////////////////////////////////////////////////
    // Branch conditions
    always_comb begin
        case (kind)
            brBgez:  taken = ($signed(rsData) >= 0);
            brBltz:  taken = ($signed(rsData) < 0);
            brBgtz:  taken = ($signed(rsData) > 0);
            brBlez:  taken = ($signed(rsData) <= 0);
            brBeq:   taken = (rsData == rtData);
            brBne:   taken = (rsData != rtData);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (kind)
            brJump, brJumpLink: nextPc = jumpTarget;
            brJumpReg:          nextPc = rsData;
            default:            nextPc = taken ? branchTarget : pcPlus4;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/RegisterFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module RegisterFile (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`REG_IDX_W-1:0] rsAddr,
    input  logic [`REG_IDX_W-1:0] rtAddr,
    input  logic [`REG_IDX_W-1:0] writeAddr,
    input  logic                  writeEn,
    input  logic [`DATA_W-1:0]    writeData,
    output logic [`DATA_W-1:0]    rsData,
    output logic [`DATA_W-1:0]    rtData
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register zero is hardwired
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

/* rtl/mipsCore_consts.svh */
`ifndef MIPS_CORE_CONSTS_SVH
`define MIPS_CORE_CONSTS_SVH

// Datapath word width
`define DATA_W 32

// Architectural register file
`define REG_CNT   32
`define REG_IDX_W 5

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* rtl/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

    // Next-PC behaviour picked by the decoder
    typedef enum logic [3:0] {
        brBgez     = 4'd0,
        brBeq      = 4'd1,
        brBne      = 4'd2,
        brBgtz     = 4'd3,
        brBlez     = 4'd4,
        brBltz     = 4'd5,
        brJump     = 4'd6,
        brJumpReg  = 4'd7,
        brJumpLink = 4'd8,
        brNone     = 4'd10
    } branchKind_t;

    typedef enum logic [1:0] {
        accWord = 2'd0,
        accHalf = 2'd1,
        accByte = 2'd2
    } accessWidth_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluMul
    } aluOp_t;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbLink = 2'd2
    } wbSel_t;

endpackage

`default_nettype wire

/* rtl/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

    // Primary opcodes handled by the decoder
    typedef enum logic [5:0] {
        opSpecial  = 6'h00,
        opRegimm   = 6'h01,
        opJ        = 6'h02,
        opJal      = 6'h03,
        opBeq      = 6'h04,
        opBne      = 6'h05,
        opBlez     = 6'h06,
        opBgtz     = 6'h07,
        opAddi     = 6'h08,
        opSlti     = 6'h0A,
        opOri      = 6'h0D,
        opXori     = 6'h0E,
        opSpecial2 = 6'h1C,
        opLb       = 6'h20,
        opLh       = 6'h21,
        opLw       = 6'h23,
        opSb       = 6'h28,
        opSh       = 6'h29,
        opSw       = 6'h2B
    } opcode_t;

    // Funct codes under SPECIAL
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2A
    } funct_t;

    // mul lives under SPECIAL2 and reuses the srl funct encoding
    localparam funct_t fnMul = funct_t'(6'h02);

    // REGIMM branches are told apart by the rt field
    localparam logic [4:0] rtBltz = 5'd0;
    localparam logic [4:0] rtBgez = 5'd1;

    // One fetched word, seen as R, I or J format
    typedef union packed {
        struct packed {
            opcode_t    opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_t     funct;
        } rFormat;
        struct packed {
            opcode_t     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFormat;
        struct packed {
            opcode_t     opcode;
            logic [25:0] target;
        } jFormat;
    } instrWord_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator and run; status follows the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module coreTb || exit 1
./obj_dir/VcoreTb | tee /dev/stderr | grep -qx '\*\*\* PASSED \*\*\*' \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

/* verif/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 10 cycles, released just after a rising edge
    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/coreTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_consts.svh"

module coreTb;

    logic               clk;
    logic               arstN;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] dmemRData;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] dmemAddr;
    logic [`DATA_W-1:0] dmemWData;
    logic [3:0]         dmemByteEn;
    logic               dmemWe;
    logic               dmemRe;

    // Program table, one entry per fetch in order
    logic [31:0] tInstr [128];
    logic [31:0] tPc    [128];
    logic        tHasSt [128];
    logic        tLoad  [128];
    logic [31:0] tAddr  [128];
    logic [3:0]  tBe    [128];
    logic [31:0] tData  [128];
    int          tTest  [128];
    int          nEntries = 0;
    int          curTest;
    logic [31:0] pcTrack;

    logic [31:0] dmem [64];
    integer      seed = 55258;
    int          errors = 0;
    int          checks = 0;
    int          testStartErr;
    int          resetCycles = 0;
    string       testName [6] = '{"reset", "arith", "loads", "stores", "branches", "jumps"};

    clockGen uClk (.clk(clk), .arstN(arstN));

    MipsCore i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .dmemRData  (dmemRData),
        .pc         (pc),
        .dmemAddr   (dmemAddr),
        .dmemWData  (dmemWData),
        .dmemByteEn (dmemByteEn),
        .dmemWe     (dmemWe),
        .dmemRe     (dmemRe)
    );

    // Data memory answers in the same cycle
    assign dmemRData = dmem[dmemAddr[7:2]];

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding
    function automatic logic [31:0] encR(input int rs, input int rt, input int rd,
                                         input int sh, input int fn);
        encR = {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] encI(input int op, input int rs, input int rt,
                                         input logic [15:0] imm);
        encI = {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] encJ(input int op, input logic [31:0] dest);
        encJ = {6'(op), dest[27:2]};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        sext16 = {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] sext8(input logic [7:0] v);
        sext8 = {{24{v[7]}}, v};
    endfunction

    // Big-endian lane k of a word
    function automatic logic [7:0] byteLane(input logic [31:0] w, input int k);
        byteLane = w[31 - 8 * k -: 8];
    endfunction

    function automatic logic condTaken(input int op, input int rtSel,
                                       input logic [31:0] a, input logic [31:0] b);
        case (op)
            1:       condTaken = (rtSel == 1) ? ($signed(a) >= 0) : ($signed(a) < 0);
            4:       condTaken = (a == b);
            5:       condTaken = (a != b);
            6:       condTaken = ($signed(a) <= 0);
            7:       condTaken = ($signed(a) > 0);
            default: condTaken = 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Table building
    task automatic addEntry(input logic [31:0] ins, input logic hasSt,
                            input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
        tInstr[nEntries] = ins;
        tPc[nEntries]    = pcTrack;
        tHasSt[nEntries] = hasSt;
        tLoad[nEntries]  = 1'b0;
        tAddr[nEntries]  = addr;
        tBe[nEntries]    = be;
        tData[nEntries]  = data;
        tTest[nEntries]  = curTest;
        nEntries++;
        pcTrack = pcTrack + 32'd4;
    endtask

    task automatic addOp(input logic [31:0] ins);
        addEntry(ins, 1'b0, '0, '0, '0);
    endtask

    // A load raises the read strobe in its cycle
    task automatic addLoad(input logic [31:0] ins);
        addOp(ins);
        tLoad[nEntries - 1] = 1'b1;
    endtask

    // sw rt, 0x80(r0) with the value expected in rt
    task automatic storeWord(input int rt, input logic [31:0] expVal);
        addEntry(encI(6'h2B, 0, rt, 16'h0080), 1'b1, 32'h80, 4'hF, expVal);
    endtask

    task automatic addBranch(input int op, input int rs, input int rt,
                             input logic [31:0] a, input logic [31:0] b);
        addOp(encI(op, rs, rt, 16'h0001));
        // A taken branch skips one instruction
        if (condTaken(op, rt, a, b)) begin
            pcTrack = pcTrack + 32'd4;
        end
        storeWord(6, 32'd7);
    endtask

    task automatic buildProgram();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] jalPc;
        w0 = dmem[0];
        w1 = dmem[1];
        pcTrack = `RESET_PC;

        curTest = 1;
        addLoad(encI(6'h23, 0, 1, 16'h0000));
        addLoad(encI(6'h23, 0, 2, 16'h0004));
        addOp(encI(6'h08, 1, 3, 16'h8765));
        storeWord(3, w0 + sext16(16'h8765));
        addOp(encI(6'h0D, 1, 3, 16'h8765));
        storeWord(3, w0 | 32'h0000_8765);
        addOp(encI(6'h0E, 1, 3, 16'hF0F0));
        storeWord(3, w0 ^ 32'h0000_F0F0);
        addOp(encI(6'h0A, 1, 3, 16'h8000));
        storeWord(3, {31'd0, $signed(w0) < $signed(sext16(16'h8000))});
        addOp(encR(1, 2, 3, 0, 6'h21));
        storeWord(3, w0 + w1);
        addOp(encR(1, 2, 3, 0, 6'h23));
        storeWord(3, w0 - w1);
        addOp(encR(1, 2, 3, 0, 6'h24));
        storeWord(3, w0 & w1);
        addOp(encR(1, 2, 3, 0, 6'h25));
        storeWord(3, w0 | w1);
        addOp(encR(1, 2, 3, 0, 6'h26));
        storeWord(3, w0 ^ w1);
        addOp(encR(1, 2, 3, 0, 6'h2A));
        storeWord(3, {31'd0, $signed(w0) < $signed(w1)});
        addOp(encR(0, 1, 3, 7, 6'h00));
        storeWord(3, w0 << 7);
        addOp(encR(0, 1, 3, 13, 6'h02));
        storeWord(3, w0 >> 13);
        // mul sits under SPECIAL2, low word of the product
        addOp({6'h1C, 5'd1, 5'd2, 5'd3, 5'd0, 6'h02});
        storeWord(3, w0 * w1);

        curTest = 2;
        for (int k = 0; k < 4; k++) begin
            addLoad(encI(6'h20, 0, 4, 16'(8 + k)));
            storeWord(4, sext8(byteLane(dmem[2], k)));
        end
        addLoad(encI(6'h21, 0, 4, 16'd12));
        storeWord(4, sext16(dmem[3][31:16]));
        addLoad(encI(6'h21, 0, 4, 16'd14));
        storeWord(4, sext16(dmem[3][15:0]));
        addLoad(encI(6'h23, 0, 4, 16'd16));
        storeWord(4, dmem[4]);

        curTest = 3;
        for (int k = 0; k < 4; k++) begin
            addEntry(encI(6'h28, 0, 1, 16'(32'h90 + k)), 1'b1, 32'h90,
                     4'(1 << (3 - k)), {4{w0[7:0]}});
        end
        addEntry(encI(6'h29, 0, 1, 16'h0094), 1'b1, 32'h94, 4'b1100, {2{w0[15:0]}});
        addEntry(encI(6'h29, 0, 1, 16'h0096), 1'b1, 32'h94, 4'b0011, {2{w0[15:0]}});

        curTest = 4;
        addOp(encI(6'h08, 0, 5, 16'hFFFB));
        addOp(encI(6'h0D, 0, 6, 16'h0007));
        addBranch(1, 5, 0, -32'sd5, 0);
        addBranch(1, 6, 0, 32'd7, 0);
        addBranch(1, 6, 1, 32'd7, 0);
        addBranch(1, 5, 1, -32'sd5, 0);
        addBranch(4, 6, 6, 32'd7, 32'd7);
        addBranch(4, 6, 5, 32'd7, -32'sd5);
        addBranch(5, 6, 5, 32'd7, -32'sd5);
        addBranch(5, 6, 6, 32'd7, 32'd7);
        addBranch(7, 6, 0, 32'd7, 0);
        addBranch(7, 0, 0, 0, 0);
        addBranch(6, 0, 0, 0, 0);
        addBranch(6, 6, 0, 32'd7, 0);

        curTest = 5;
        addOp(encJ(2, pcTrack + 32'd12));
        pcTrack = pcTrack + 32'd8;
        jalPc = pcTrack;
        addOp(encJ(3, jalPc + 32'd16));
        pcTrack = jalPc + 32'd16;
        storeWord(31, jalPc + 32'd4);
        addOp(encR(31, 0, 0, 0, 6'h08));
        pcTrack = jalPc + 32'd4;
        storeWord(6, 32'd7);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    task automatic checkEq(input logic [31:0] got, input logic [31:0] expVal,
                           input string msg);
        checks++;
        if (got !== expVal) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, expVal);
        end
    endtask

    task automatic endTest(input int id);
        $display("Test %0d %s: %s (%0d errors)", id, testName[id],
                 (errors == testStartErr) ? "ok" : "bad", errors - testStartErr);
        testStartErr = errors;
    endtask

    // Watchdog sized from the table length
    initial begin
        wait (nEntries > 0);
        #((nEntries * 20 + 10) * 10);
        $display("Timeout: the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        buildProgram();
        // A store early in reset and the first load later both meet the strobe gating
        instr = encI(6'h2B, 0, 1, 16'h0080);
        testStartErr = 0;
        #1;

        while (arstN !== 1'b1) begin
            @(negedge clk or posedge arstN);
            if (arstN !== 1'b1) begin
                checkEq(pc, `RESET_PC, "pc in reset");
                checkEq(dmemWe, 0, "dmemWe in reset");
                checkEq(dmemRe, 0, "dmemRe in reset");
                resetCycles++;
                if (resetCycles == 4) begin
                    @(posedge clk);
                    #1;
                    instr = tInstr[0];
                end
            end
        end
        endTest(0);

        for (int i = 0; i < nEntries; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #1;
                instr = tInstr[i];
            end
            checkEq(pc, tPc[i], $sformatf("pc at entry %0d", i));
            @(negedge clk);
            checkEq(dmemWe, tHasSt[i], $sformatf("store strobe at entry %0d", i));
            checkEq(dmemRe, tLoad[i], $sformatf("read strobe at entry %0d", i));
            if (tHasSt[i] && dmemWe) begin
                checkEq(dmemAddr, tAddr[i], $sformatf("store address at entry %0d", i));
                checkEq(dmemByteEn, tBe[i], $sformatf("byte enables at entry %0d", i));
                checkEq(dmemWData, tData[i], $sformatf("store data at entry %0d", i));
            end
            if (i == nEntries - 1 || tTest[i + 1] != tTest[i]) begin
                endTest(tTest[i]);
            end
        end

        $display("Done: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
